// ==== csr_unit.f ====
+incdir+verif
rtl/csr_arch_pkg.sv
rtl/csr_ctrl_pkg.sv
rtl/csr_decode.sv
rtl/csr_trap_regs.sv
rtl/csr_int_ctrl.sv
rtl/csr_read_port.sv
rtl/csr_unit.sv
verif/tb_csr_unit.sv

// ==== rtl/csr_arch_pkg.sv ====
package csr_arch_pkg;

    localparam int XLEN = 32;
    localparam int CSR_ADDR_W = 12;
    localparam int CAUSE_W = 5;        // flag plus code, as it arrives on addr_cause
    localparam int CAUSE_CODE_W = 4;

    typedef enum logic [2:0] {
        OP_EXCEPTION = 3'b000,
        OP_MRET      = 3'b001,
        OP_NOP       = 3'b011,
        OP_CSRRW     = 3'b101,
        OP_CSRRS     = 3'b110,
        OP_CSRRC     = 3'b111
    } csr_op_e;                        // 010 and 100 are illegal

    localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIE     = 12'h304;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE  = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] ADDR_MIP     = 12'h344;

    // mstatus
    localparam int BIT_MIE  = 3;
    localparam int BIT_MPIE = 7;

    // mie and mip share the layout
    localparam int BIT_SW  = 3;
    localparam int BIT_EXT = 11;

    localparam int BIT_CAUSE_INT = 31; // mcause interrupt flag
    localparam int CAUSE_FLAG_BIT = 4; // flag position in the trap cause field

    localparam logic [CAUSE_W-1:0] CAUSE_EXT_INT = 5'h1B;
    localparam logic [CAUSE_W-1:0] CAUSE_SW_INT  = 5'h13;

    localparam logic [XLEN-1:0] IRQ_HANDLER_ADDR = 32'h0000_0010;

endpackage

// ==== rtl/csr_ctrl_pkg.sv ====
package csr_ctrl_pkg;

    typedef struct packed {
        logic mstatus;
        logic mie;
        logic mepc;
        logic mcause;
        logic mip;
        logic addr_valid;              // any of the five
    } csr_sel_t;

    typedef struct packed {
        logic en;
        logic is_csr;
        logic is_exception;
        logic is_mret;
        logic is_nop;
        logic wr_csr;                  // write phase, en high
        logic wr_trap;
        logic wr_mret;
        logic rd_phase;
        logic illegal;
        csr_sel_t sel;
        logic [csr_arch_pkg::XLEN-1:0] set_mask;
        logic [csr_arch_pkg::XLEN-1:0] keep_mask;
    } csr_cmd_t;

    typedef struct packed {
        logic mie;
        logic mpie;
        logic [csr_arch_pkg::XLEN-1:0] mepc;
        logic cause_int;
        logic [csr_arch_pkg::CAUSE_CODE_W-1:0] cause_code;
    } trap_state_t;

    typedef struct packed {
        logic meie;
        logic msie;
        logic meip;
        logic msip;
    } int_state_t;

    // new field value from the op masks and the old value
    function automatic logic [csr_arch_pkg::XLEN-1:0] apply_mask(
        input csr_cmd_t cmd,
        input logic [csr_arch_pkg::XLEN-1:0] old
    );
        return cmd.set_mask | (cmd.keep_mask & old);
    endfunction

endpackage

// ==== rtl/csr_decode.sv ====
`timescale 1ns/1ps

module csr_decode (
    input  csr_arch_pkg::csr_op_e                op,
    input  logic [csr_arch_pkg::CSR_ADDR_W-1:0]  addr_cause,
    input  logic [csr_arch_pkg::XLEN-1:0]        write_value,
    input  logic                                 write_phase,
    input  logic                                 en,
    output csr_ctrl_pkg::csr_cmd_t               cmd
);

    logic bad_op;

    always_comb begin
        cmd = '0;
        bad_op = 1'b0;
        cmd.en = en;

        case (op)
            csr_arch_pkg::OP_EXCEPTION: begin
                cmd.is_exception = 1'b1;
            end
            csr_arch_pkg::OP_MRET: begin
                cmd.is_mret = 1'b1;
            end
            csr_arch_pkg::OP_NOP: begin
                cmd.is_nop = 1'b1;
            end
            csr_arch_pkg::OP_CSRRW: begin
                cmd.is_csr = 1'b1;
                cmd.set_mask = write_value;
                cmd.keep_mask = '0;
            end
            csr_arch_pkg::OP_CSRRS: begin
                cmd.is_csr = 1'b1;
                cmd.set_mask = write_value;
                cmd.keep_mask = '1;    // keep everything not set
            end
            csr_arch_pkg::OP_CSRRC: begin
                cmd.is_csr = 1'b1;
                cmd.set_mask = '0;
                cmd.keep_mask = ~write_value;
            end
            default: begin
                bad_op = 1'b1;
            end
        endcase

        cmd.sel.mstatus = addr_cause == csr_arch_pkg::ADDR_MSTATUS;
        cmd.sel.mie     = addr_cause == csr_arch_pkg::ADDR_MIE;
        cmd.sel.mepc    = addr_cause == csr_arch_pkg::ADDR_MEPC;
        cmd.sel.mcause  = addr_cause == csr_arch_pkg::ADDR_MCAUSE;
        cmd.sel.mip     = addr_cause == csr_arch_pkg::ADDR_MIP;
        cmd.sel.addr_valid = cmd.sel.mstatus | cmd.sel.mie | cmd.sel.mepc |
                             cmd.sel.mcause | cmd.sel.mip;

        cmd.wr_csr   = en & write_phase & cmd.is_csr;
        cmd.wr_trap  = en & write_phase & cmd.is_exception;
        cmd.wr_mret  = en & write_phase & cmd.is_mret;
        cmd.rd_phase = en & ~write_phase;

        cmd.illegal = bad_op | (cmd.is_csr & ~cmd.sel.addr_valid);
    end

endmodule

// ==== rtl/csr_int_ctrl.sv ====
`timescale 1ns/1ps

module csr_int_ctrl (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 en,
    input  logic                                 ext_int,
    input  csr_ctrl_pkg::csr_cmd_t               cmd,
    input  logic [csr_arch_pkg::CSR_ADDR_W-1:0]  addr_cause,
    input  csr_ctrl_pkg::trap_state_t            trap,
    output csr_ctrl_pkg::int_state_t             ints,
    output logic                                 ext_int_pending,
    output logic                                 sw_int_pending
);

    csr_ctrl_pkg::int_state_t ints_q;

    logic [csr_arch_pkg::XLEN-1:0] mie_old;
    logic [csr_arch_pkg::XLEN-1:0] mip_old;
    logic [csr_arch_pkg::XLEN-1:0] mie_new;
    logic [csr_arch_pkg::XLEN-1:0] mip_new;
    logic clr_ext;
    logic clr_sw;
    logic wr_mie;
    logic wr_mip;

    always_comb begin
        mie_old = '0;
        mie_old[csr_arch_pkg::BIT_EXT] = ints_q.meie;
        mie_old[csr_arch_pkg::BIT_SW] = ints_q.msie;
        mip_old = '0;
        mip_old[csr_arch_pkg::BIT_EXT] = ints_q.meip;
        mip_old[csr_arch_pkg::BIT_SW] = ints_q.msip;
    end

    assign mie_new = csr_ctrl_pkg::apply_mask(cmd, mie_old);
    assign mip_new = csr_ctrl_pkg::apply_mask(cmd, mip_old);

    assign wr_mie = cmd.wr_csr & cmd.sel.mie;
    assign wr_mip = cmd.wr_csr & cmd.sel.mip;
    assign clr_ext = cmd.wr_trap &
        (addr_cause[csr_arch_pkg::CAUSE_W-1:0] == csr_arch_pkg::CAUSE_EXT_INT);
    assign clr_sw = cmd.wr_trap &
        (addr_cause[csr_arch_pkg::CAUSE_W-1:0] == csr_arch_pkg::CAUSE_SW_INT);

    always_ff @(posedge clk) begin
        if (rst) begin
            ints_q <= '0;
            ext_int_pending <= 1'b0;
            sw_int_pending <= 1'b0;
        end else begin
            if (wr_mie) begin
                ints_q.meie <= mie_new[csr_arch_pkg::BIT_EXT];
                ints_q.msie <= mie_new[csr_arch_pkg::BIT_SW];
            end

            if (ext_int) begin
                ints_q.meip <= 1'b1;   // level wins over everything, en or not
            end else if (clr_ext) begin
                ints_q.meip <= 1'b0;
            end else if (wr_mip) begin
                ints_q.meip <= mip_new[csr_arch_pkg::BIT_EXT];
            end

            if (clr_sw) begin
                ints_q.msip <= 1'b0;
            end else if (wr_mip) begin
                ints_q.msip <= mip_new[csr_arch_pkg::BIT_SW];
            end

            ext_int_pending <= ints_q.meip & ints_q.meie & trap.mie;
            sw_int_pending <= ints_q.msip & ints_q.msie & trap.mie;
        end
    end

    assign ints = ints_q;

    a_pending_terms: assert property (@(posedge clk) disable iff (rst)
        (ext_int_pending |-> $past(ints_q.meip && ints_q.meie && trap.mie)) and
        (sw_int_pending |-> $past(ints_q.msip && ints_q.msie && trap.mie)));

    // decode gating must keep software state frozen while the core is stalled
    a_hold_when_idle: assert property (@(posedge clk) disable iff (rst)
        !en |=> $stable({ints_q.meie, ints_q.msie, ints_q.msip}));

endmodule

// ==== rtl/csr_read_port.sv ====
`timescale 1ns/1ps

module csr_read_port (
    input  logic                          clk,
    input  logic                          rst,
    input  csr_ctrl_pkg::csr_cmd_t        cmd,
    input  csr_ctrl_pkg::trap_state_t     trap,
    input  csr_ctrl_pkg::int_state_t      ints,
    output logic [csr_arch_pkg::XLEN-1:0] read_value,
    output logic                          fault
);

    logic [csr_arch_pkg::XLEN-1:0] csr_value;
    logic [csr_arch_pkg::XLEN-1:0] next_value;
    logic load;

    always_comb begin
        csr_value = '0;
        if (cmd.sel.mstatus) begin
            csr_value[csr_arch_pkg::BIT_MIE] = trap.mie;
            csr_value[csr_arch_pkg::BIT_MPIE] = trap.mpie;
        end else if (cmd.sel.mie) begin
            csr_value[csr_arch_pkg::BIT_EXT] = ints.meie;
            csr_value[csr_arch_pkg::BIT_SW] = ints.msie;
        end else if (cmd.sel.mepc) begin
            csr_value = trap.mepc;
        end else if (cmd.sel.mcause) begin
            csr_value[csr_arch_pkg::BIT_CAUSE_INT] = trap.cause_int;
            csr_value[csr_arch_pkg::CAUSE_CODE_W-1:0] = trap.cause_code;
        end else if (cmd.sel.mip) begin
            csr_value[csr_arch_pkg::BIT_EXT] = ints.meip;
            csr_value[csr_arch_pkg::BIT_SW] = ints.msip;
        end
    end

    always_comb begin
        if (cmd.is_exception) begin
            next_value = csr_arch_pkg::IRQ_HANDLER_ADDR;
        end else if (cmd.is_mret) begin
            next_value = trap.mepc; // return address
        end else begin
            next_value = csr_value;
        end
    end

    assign load = cmd.rd_phase &
        (cmd.is_exception | cmd.is_mret | (cmd.is_csr & cmd.sel.addr_valid));

    always_ff @(posedge clk) begin
        if (rst) begin
            read_value <= '0;
            fault <= 1'b0;
        end else begin
            if (load) begin
                read_value <= next_value;
            end
            if (cmd.en) begin
                fault <= cmd.illegal; // both phases
            end
        end
    end

    a_fault_after_reset: assert property (@(posedge clk)
        rst |=> !fault);

endmodule

// ==== rtl/csr_trap_regs.sv ====
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                                 clk,
    input  logic                                 rst,
    input  csr_ctrl_pkg::csr_cmd_t               cmd,
    input  logic [csr_arch_pkg::CSR_ADDR_W-1:0]  addr_cause,
    input  logic [csr_arch_pkg::XLEN-1:0]        write_value,
    output csr_ctrl_pkg::trap_state_t            trap
);

    csr_ctrl_pkg::trap_state_t state_q;
    logic stack_q;                     // MIE on trap read, MPIE on mret read

    logic [csr_arch_pkg::XLEN-1:0] mstatus_old;
    logic [csr_arch_pkg::XLEN-1:0] mcause_old;
    logic [csr_arch_pkg::XLEN-1:0] mstatus_new;
    logic [csr_arch_pkg::XLEN-1:0] mepc_new;
    logic [csr_arch_pkg::XLEN-1:0] mcause_new;

    always_comb begin
        mstatus_old = '0;
        mstatus_old[csr_arch_pkg::BIT_MIE] = state_q.mie;
        mstatus_old[csr_arch_pkg::BIT_MPIE] = state_q.mpie;
        mcause_old = '0;
        mcause_old[csr_arch_pkg::BIT_CAUSE_INT] = state_q.cause_int;
        mcause_old[csr_arch_pkg::CAUSE_CODE_W-1:0] = state_q.cause_code;
    end

    assign mstatus_new = csr_ctrl_pkg::apply_mask(cmd, mstatus_old);
    assign mepc_new    = csr_ctrl_pkg::apply_mask(cmd, state_q.mepc);
    assign mcause_new  = csr_ctrl_pkg::apply_mask(cmd, mcause_old);

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= '0;
            stack_q <= 1'b0;
        end else begin
            if (cmd.rd_phase && cmd.is_exception) begin
                stack_q <= state_q.mie;
            end else if (cmd.rd_phase && cmd.is_mret) begin
                stack_q <= state_q.mpie;
            end

            if (cmd.wr_trap) begin
                state_q.mepc <= {write_value[csr_arch_pkg::XLEN-1:2], 2'b00};
                state_q.cause_int <= addr_cause[csr_arch_pkg::CAUSE_FLAG_BIT];
                state_q.cause_code <= addr_cause[csr_arch_pkg::CAUSE_CODE_W-1:0];
                state_q.mie <= 1'b0;
                state_q.mpie <= stack_q;
            end else if (cmd.wr_mret) begin
                state_q.mie <= stack_q;
            end else if (cmd.wr_csr) begin
                if (cmd.sel.mstatus) begin
                    state_q.mie <= mstatus_new[csr_arch_pkg::BIT_MIE];
                    state_q.mpie <= mstatus_new[csr_arch_pkg::BIT_MPIE];
                end
                if (cmd.sel.mepc) begin
                    state_q.mepc <= {mepc_new[csr_arch_pkg::XLEN-1:2], 2'b00}; // word aligned
                end
                if (cmd.sel.mcause) begin
                    state_q.cause_int <= mcause_new[csr_arch_pkg::BIT_CAUSE_INT];
                    state_q.cause_code <= mcause_new[csr_arch_pkg::CAUSE_CODE_W-1:0];
                end
            end
        end
    end

    assign trap = state_q;

    // interrupts stay masked on handler entry
    a_trap_clears_mie: assert property (@(posedge clk) disable iff (rst)
        cmd.wr_trap |=> !trap.mie);

endmodule

// ==== rtl/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 en,
    input  logic                                 write_phase,
    input  logic                                 ext_int,
    input  csr_arch_pkg::csr_op_e                op,
    input  logic [csr_arch_pkg::CSR_ADDR_W-1:0]  addr_cause,
    input  logic [csr_arch_pkg::XLEN-1:0]        write_value,
    output logic [csr_arch_pkg::XLEN-1:0]        read_value,
    output logic                                 ext_int_pending,
    output logic                                 sw_int_pending,
    output logic                                 fault
);

    csr_ctrl_pkg::csr_cmd_t cmd;
    csr_ctrl_pkg::trap_state_t trap;
    csr_ctrl_pkg::int_state_t ints;

    csr_decode decode0 (
        .op          (op),
        .addr_cause  (addr_cause),
        .write_value (write_value),
        .write_phase (write_phase),
        .en          (en),
        .cmd         (cmd)
    );

    csr_trap_regs trap_regs0 (
        .clk         (clk),
        .rst         (rst),
        .cmd         (cmd),
        .addr_cause  (addr_cause),
        .write_value (write_value),
        .trap        (trap)
    );

    csr_int_ctrl int_ctrl0 (
        .clk             (clk),
        .rst             (rst),
        .en              (en),
        .ext_int         (ext_int),
        .cmd             (cmd),
        .addr_cause      (addr_cause),
        .trap            (trap),
        .ints            (ints),
        .ext_int_pending (ext_int_pending),
        .sw_int_pending  (sw_int_pending)
    );

    csr_read_port read_port0 (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd),
        .trap       (trap),
        .ints       (ints),
        .read_value (read_value),
        .fault      (fault)
    );

endmodule

// ==== verif/csr_unit_tests.svh ====
`ifndef CSR_UNIT_TESTS_SVH
`define CSR_UNIT_TESTS_SVH

task automatic check_reset_state();
    logic [31:0] rv;
    logic flt;
    @(negedge clk);
    check_eq("read_value", read_value, 32'h0);
    check_eq("fault", {31'b0, fault}, 32'h0);
    check_eq("ext_int_pending", {31'b0, ext_int_pending}, 32'h0);
    check_eq("sw_int_pending", {31'b0, sw_int_pending}, 32'h0);
    for (int i = 0; i < 5; i++) begin
        csr_op(csr_arch_pkg::OP_CSRRS, csr_addr(i), 32'h0, rv, flt);
        check_eq($sformatf("reset value csr 0x%03h", csr_addr(i)), rv, 32'h0);
    end
endtask

task automatic exercise_csr_ops();
    logic [11:0] a;
    for (int i = 0; i < 5; i++) begin
        a = csr_addr(i);
        csr_access(csr_arch_pkg::OP_CSRRW, a, $urandom);
        csr_access(csr_arch_pkg::OP_CSRRS, a, $urandom);
        csr_access(csr_arch_pkg::OP_CSRRC, a, $urandom);
        csr_access(csr_arch_pkg::OP_CSRRW, a, 32'h0); // shows the result of the clear
    end
    for (int i = 0; i < 5; i++) begin
        csr_access(csr_arch_pkg::OP_CSRRS, csr_addr(i), 32'h0);
    end
endtask

task automatic trap_and_return();
    logic [31:0] pc;
    logic [31:0] r;
    for (int i = 0; i < 2; i++) begin
        // first pass with MIE set, second with only MPIE set
        csr_access(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MSTATUS,
                   i == 0 ? 32'h0000_0008 : 32'h0000_0080);
        pc = $urandom;
        r = $urandom;
        take_trap(pc, r[4:0]);
        csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MEPC, 32'h0);
        csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MCAUSE, 32'h0);
        csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MSTATUS, 32'h0);
        do_mret();
        csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MSTATUS, 32'h0);
    end
endtask

task automatic raise_and_clear_interrupts();
    csr_access(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MSTATUS, 32'h0000_0008);
    csr_access(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MIE, 32'h0000_0808);
    @(posedge clk);
    ext_int <= 1'b1;
    @(posedge clk);
    ext_int <= 1'b0;
    m.meip = 1'b1;
    @(posedge clk);                    // pending output registered here
    for (int i = 0; i < 4; i++) begin
        @(negedge clk);
        check_eq("ext_int_pending", {31'b0, ext_int_pending}, 32'h1);
    end
    take_trap(32'h0000_1000, csr_arch_pkg::CAUSE_EXT_INT);
    @(posedge clk);
    @(negedge clk);
    check_eq("ext_int_pending", {31'b0, ext_int_pending}, 32'h0);

    do_mret();                         // MIE back on
    csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MIP, 32'h0000_0008);
    @(posedge clk);
    @(negedge clk);
    check_eq("sw_int_pending", {31'b0, sw_int_pending}, 32'h1);
    check_eq("ext_int_pending", {31'b0, ext_int_pending}, 32'h0);
    take_trap(32'h0000_2004, csr_arch_pkg::CAUSE_SW_INT);
    @(posedge clk);
    @(negedge clk);
    check_eq("sw_int_pending", {31'b0, sw_int_pending}, 32'h0);
    csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MIP, 32'h0);
    csr_access(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MIE, 32'h0);
endtask

task automatic flag_illegal_ops();
    logic [31:0] rv_before;
    logic [31:0] rv;
    logic flt;
    rv_before = csr_layout(csr_arch_pkg::ADDR_MEPC);
    csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MEPC, 32'h0); // known read_value
    csr_op(csr_arch_pkg::csr_op_e'(3'b010), csr_arch_pkg::ADDR_MSTATUS, 32'h0, rv, flt);
    check_eq("fault op 010", {31'b0, flt}, 32'h1);
    check_eq("read_value", rv, rv_before);
    csr_op(csr_arch_pkg::csr_op_e'(3'b100), csr_arch_pkg::ADDR_MSTATUS, 32'h0, rv, flt);
    check_eq("fault op 100", {31'b0, flt}, 32'h1);
    check_eq("read_value", rv, rv_before);
    csr_op(csr_arch_pkg::OP_CSRRW, 12'h305, $urandom, rv, flt);
    check_eq("fault csr 0x305", {31'b0, flt}, 32'h1);
    check_eq("read_value", rv, rv_before);
    csr_op(csr_arch_pkg::OP_NOP, 12'h000, 32'h0, rv, flt);
    check_eq("fault nop", {31'b0, flt}, 32'h0);
    check_eq("read_value", rv, rv_before);
endtask

task automatic hold_with_en_low();
    csr_access(csr_arch_pkg::OP_CSRRW, csr_arch_pkg::ADDR_MEPC, $urandom);
    @(posedge clk);
    en <= 1'b1;
    write_phase <= 1'b0;
    op <= csr_arch_pkg::OP_CSRRW;
    addr_cause <= csr_arch_pkg::ADDR_MEPC;
    write_value <= $urandom;
    @(posedge clk);
    en <= 1'b0;                        // write phase without en
    write_phase <= 1'b1;
    ext_int <= 1'b1;
    @(posedge clk);
    write_phase <= 1'b0;
    ext_int <= 1'b0;
    op <= csr_arch_pkg::OP_NOP;
    m.meip = 1'b1;
    csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MEPC, 32'h0);
    csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MSTATUS, 32'h0);
    csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MIP, 32'h0);
    csr_access(csr_arch_pkg::OP_CSRRC, csr_arch_pkg::ADDR_MIP, 32'h0000_0800);
    csr_access(csr_arch_pkg::OP_CSRRS, csr_arch_pkg::ADDR_MIP, 32'h0);
endtask

`endif

// ==== verif/tb_csr_unit.sv ====
`timescale 1ns/1ps

module tb_csr_unit;

    localparam int TIMEOUT_CYCLES = 2000; // the test sequence runs about 300

    typedef struct packed {
        logic mie;
        logic mpie;
        logic [31:0] mepc;
        logic cause_int;
        logic [3:0] cause_code;
        logic meie;
        logic msie;
        logic meip;
        logic msip;
        logic stack;                   // MIE or MPIE captured in the read phase
    } model_t;

    logic clk;
    logic rst;
    logic en;
    logic write_phase;
    logic ext_int;
    csr_arch_pkg::csr_op_e op;
    logic [11:0] addr_cause;
    logic [31:0] write_value;
    logic [31:0] read_value;
    logic ext_int_pending;
    logic sw_int_pending;
    logic fault;

    model_t m;
    int unsigned cycles = 0;

    csr_unit dut0 (
        .clk             (clk),
        .rst             (rst),
        .en              (en),
        .write_phase     (write_phase),
        .ext_int         (ext_int),
        .op              (op),
        .addr_cause      (addr_cause),
        .write_value     (write_value),
        .read_value      (read_value),
        .ext_int_pending (ext_int_pending),
        .sw_int_pending  (sw_int_pending),
        .fault           (fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
        if (got !== expected) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    function automatic logic [11:0] csr_addr(input int i);
        case (i)
            0: return csr_arch_pkg::ADDR_MSTATUS;
            1: return csr_arch_pkg::ADDR_MIE;
            2: return csr_arch_pkg::ADDR_MEPC;
            3: return csr_arch_pkg::ADDR_MCAUSE;
            default: return csr_arch_pkg::ADDR_MIP;
        endcase
    endfunction

    // architectural view of a CSR built from the model fields
    function automatic logic [31:0] csr_layout(input logic [11:0] a);
        logic [31:0] v;
        v = '0;
        case (a)
            csr_arch_pkg::ADDR_MSTATUS: begin
                v[csr_arch_pkg::BIT_MIE] = m.mie;
                v[csr_arch_pkg::BIT_MPIE] = m.mpie;
            end
            csr_arch_pkg::ADDR_MIE: begin
                v[csr_arch_pkg::BIT_EXT] = m.meie;
                v[csr_arch_pkg::BIT_SW] = m.msie;
            end
            csr_arch_pkg::ADDR_MEPC: v = m.mepc;
            csr_arch_pkg::ADDR_MCAUSE: begin
                v[csr_arch_pkg::BIT_CAUSE_INT] = m.cause_int;
                v[3:0] = m.cause_code;
            end
            csr_arch_pkg::ADDR_MIP: begin
                v[csr_arch_pkg::BIT_EXT] = m.meip;
                v[csr_arch_pkg::BIT_SW] = m.msip;
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    function automatic logic [31:0] masked(input csr_arch_pkg::csr_op_e o,
                                           input logic [31:0] wv, input logic [31:0] old);
        case (o)
            csr_arch_pkg::OP_CSRRW: return wv;
            csr_arch_pkg::OP_CSRRS: return old | wv;
            default: return old & ~wv;
        endcase
    endfunction

    task automatic model_csr_write(input csr_arch_pkg::csr_op_e o, input logic [11:0] a,
                                   input logic [31:0] wv);
        logic [31:0] nv;
        nv = masked(o, wv, csr_layout(a));
        case (a)
            csr_arch_pkg::ADDR_MSTATUS: begin
                m.mie = nv[csr_arch_pkg::BIT_MIE];
                m.mpie = nv[csr_arch_pkg::BIT_MPIE];
            end
            csr_arch_pkg::ADDR_MIE: begin
                m.meie = nv[csr_arch_pkg::BIT_EXT];
                m.msie = nv[csr_arch_pkg::BIT_SW];
            end
            csr_arch_pkg::ADDR_MEPC: m.mepc = {nv[31:2], 2'b00};
            csr_arch_pkg::ADDR_MCAUSE: begin
                m.cause_int = nv[csr_arch_pkg::BIT_CAUSE_INT];
                m.cause_code = nv[3:0];
            end
            csr_arch_pkg::ADDR_MIP: begin
                m.meip = nv[csr_arch_pkg::BIT_EXT];
                m.msip = nv[csr_arch_pkg::BIT_SW];
            end
            default: ;
        endcase
    endtask

    // read phase, then write phase; outputs sampled after the read edge
    task automatic csr_op(input csr_arch_pkg::csr_op_e o, input logic [11:0] a,
                          input logic [31:0] wv, output logic [31:0] rv, output logic flt);
        @(posedge clk);
        en <= 1'b1;
        write_phase <= 1'b0;
        op <= o;
        addr_cause <= a;
        write_value <= wv;
        @(posedge clk);
        write_phase <= 1'b1;
        @(negedge clk);
        rv = read_value;
        flt = fault;
        @(posedge clk);
        en <= 1'b0;
        write_phase <= 1'b0;
        op <= csr_arch_pkg::OP_NOP;
    endtask

    task automatic csr_access(input csr_arch_pkg::csr_op_e o, input logic [11:0] a,
                              input logic [31:0] wv);
        logic [31:0] expected;
        logic [31:0] rv;
        logic flt;
        expected = csr_layout(a);
        csr_op(o, a, wv, rv, flt);
        check_eq($sformatf("read_value csr 0x%03h", a), rv, expected);
        check_eq("fault", {31'b0, flt}, 32'h0);
        model_csr_write(o, a, wv);
    endtask

    task automatic take_trap(input logic [31:0] pc, input logic [4:0] cause);
        logic [31:0] rv;
        logic flt;
        csr_op(csr_arch_pkg::OP_EXCEPTION, {7'b0, cause}, pc, rv, flt);
        check_eq("read_value trap", rv, csr_arch_pkg::IRQ_HANDLER_ADDR);
        m.stack = m.mie;
        m.mepc = {pc[31:2], 2'b00};
        m.cause_int = cause[4];
        m.cause_code = cause[3:0];
        m.mie = 1'b0;
        m.mpie = m.stack;
        if (cause == csr_arch_pkg::CAUSE_EXT_INT) begin
            m.meip = 1'b0;
        end
        if (cause == csr_arch_pkg::CAUSE_SW_INT) begin
            m.msip = 1'b0;
        end
    endtask

    task automatic do_mret();
        logic [31:0] rv;
        logic flt;
        csr_op(csr_arch_pkg::OP_MRET, 12'h000, 32'h0, rv, flt);
        check_eq("read_value mret", rv, m.mepc);
        m.stack = m.mpie;
        m.mie = m.stack;
    endtask

    `include "csr_unit_tests.svh"

    initial begin
        void'($urandom(85));
        m = '0;
        rst = 1'b1;
        en = 1'b0;
        write_phase = 1'b0;
        ext_int = 1'b0;
        op = csr_arch_pkg::OP_NOP;
        addr_cause = '0;
        write_value = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        check_reset_state();
        exercise_csr_ops();
        trap_and_return();
        raise_and_clear_interrupts();
        flag_illegal_ops();
        hold_with_en_low();

        $display("Test passed");
        $finish;
    end

endmodule
